// ==== source/bypass_pkg.sv ====
`default_nettype none

package bypass_pkg;

    // datapath width shared by the register file, the lanes and the data memory.
    localparam int data_w = 32;

    typedef logic [4:0] reg_addr_t;

    // zero-extended load offset.
    typedef logic [5:0] imm_t;

    typedef enum logic [2:0] {
        OP_NOP  = 3'd0,
        OP_ADD  = 3'd1,
        OP_SUB  = 3'd2,
        OP_AND  = 3'd3,
        OP_OR   = 3'd4,
        OP_LOAD = 3'd5
    } op_t;

    // old is slot 0, first in program order. young is slot 1.
    typedef enum logic [2:0] {
        FWD_NONE           = 3'd0,
        FWD_EX_YOUNG_ALU   = 3'd1,
        FWD_EX_OLD_ALU     = 3'd2,
        FWD_MEM_YOUNG_ALU  = 3'd3,
        FWD_MEM_YOUNG_LOAD = 3'd4,
        FWD_MEM_OLD_ALU    = 3'd5,
        FWD_MEM_OLD_LOAD   = 3'd6
    } fwd_sel_t;

    // a nonzero dst on any op except OP_NOP writes the register file.
    typedef struct packed {
        op_t       op;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t dst;
        imm_t      imm;
    } instr_t;

endpackage

`default_nettype wire

// ==== source/lane_result_if.sv ====
`default_nettype none

interface lane_result_if import bypass_pkg::*; ();

    logic              valid;
    logic              w_ena;     // already qualified by valid and a nonzero dst.
    reg_addr_t         dst;
    logic              is_load;
    logic [data_w-1:0] alu_res;   // holds the load address in execute when is_load is set.
    logic [data_w-1:0] load_data;

    modport producer (
        output valid,
        output w_ena,
        output dst,
        output is_load,
        output alu_res,
        output load_data
    );

    modport consumer (
        input  valid,
        input  w_ena,
        input  dst,
        input  is_load,
        input  alu_res,
        input  load_data
    );

endinterface

`default_nettype wire

// ==== source/operand_forward.sv ====
`default_nettype none

module operand_forward import bypass_pkg::*; (
    input  reg_addr_t       id_rs,
    input  reg_addr_t       id_rt,
    lane_result_if.consumer ex_old,
    lane_result_if.consumer ex_young,
    lane_result_if.consumer mem_old,
    lane_result_if.consumer mem_young,
    output fwd_sel_t        fwd_rs,
    output fwd_sel_t        fwd_rt,
    output logic            stall_req
);

    logic rs_hit_ex_young;
    logic rs_hit_ex_old;
    logic rs_hit_mem_young_alu;
    logic rs_hit_mem_young_load;
    logic rs_hit_mem_old_alu;
    logic rs_hit_mem_old_load;

    logic rt_hit_ex_young;
    logic rt_hit_ex_old;
    logic rt_hit_mem_young_alu;
    logic rt_hit_mem_young_load;
    logic rt_hit_mem_old_alu;
    logic rt_hit_mem_old_load;

    // younger slot before older slot, execute before memory.
    function automatic fwd_sel_t encode_sel(
        input logic hit_ex_young,
        input logic hit_ex_old,
        input logic hit_mem_young_alu,
        input logic hit_mem_young_load,
        input logic hit_mem_old_alu,
        input logic hit_mem_old_load
    );
        fwd_sel_t sel;
        if (hit_ex_young) begin
            sel = FWD_EX_YOUNG_ALU;
        end else if (hit_ex_old) begin
            sel = FWD_EX_OLD_ALU;
        end else if (hit_mem_young_alu) begin
            sel = FWD_MEM_YOUNG_ALU;
        end else if (hit_mem_young_load) begin
            sel = FWD_MEM_YOUNG_LOAD;
        end else if (hit_mem_old_alu) begin
            sel = FWD_MEM_OLD_ALU;
        end else if (hit_mem_old_load) begin
            sel = FWD_MEM_OLD_LOAD;
        end else begin
            sel = FWD_NONE;
        end
        return sel;
    endfunction

    assign rs_hit_ex_young = ex_young.w_ena & (ex_young.dst == id_rs);
    assign rs_hit_ex_old   = ex_old.w_ena & (ex_old.dst == id_rs);
    assign rt_hit_ex_young = ex_young.w_ena & (ex_young.dst == id_rt);
    assign rt_hit_ex_old   = ex_old.w_ena & (ex_old.dst == id_rt);

    // a memory-stage load can only supply its loaded word.
    assign rs_hit_mem_young_alu  = mem_young.w_ena & (mem_young.dst == id_rs) & ~mem_young.is_load;
    assign rs_hit_mem_young_load = mem_young.w_ena & (mem_young.dst == id_rs) & mem_young.is_load;
    assign rs_hit_mem_old_alu    = mem_old.w_ena & (mem_old.dst == id_rs) & ~mem_old.is_load;
    assign rs_hit_mem_old_load   = mem_old.w_ena & (mem_old.dst == id_rs) & mem_old.is_load;

    assign rt_hit_mem_young_alu  = mem_young.w_ena & (mem_young.dst == id_rt) & ~mem_young.is_load;
    assign rt_hit_mem_young_load = mem_young.w_ena & (mem_young.dst == id_rt) & mem_young.is_load;
    assign rt_hit_mem_old_alu    = mem_old.w_ena & (mem_old.dst == id_rt) & ~mem_old.is_load;
    assign rt_hit_mem_old_load   = mem_old.w_ena & (mem_old.dst == id_rt) & mem_old.is_load;

    assign fwd_rs = encode_sel(rs_hit_ex_young, rs_hit_ex_old, rs_hit_mem_young_alu,
                               rs_hit_mem_young_load, rs_hit_mem_old_alu, rs_hit_mem_old_load);
    assign fwd_rt = encode_sel(rt_hit_ex_young, rt_hit_ex_old, rt_hit_mem_young_alu,
                               rt_hit_mem_young_load, rt_hit_mem_old_alu, rt_hit_mem_old_load);

    // the loaded word is not ready until the memory stage.
    assign stall_req = ((rs_hit_ex_young | rt_hit_ex_young) & ex_young.is_load) |
                       ((rs_hit_ex_old | rt_hit_ex_old) & ex_old.is_load);

    always_comb begin
        assert (stall_req ||
                !((fwd_rs == FWD_EX_YOUNG_ALU && ex_young.is_load) ||
                  (fwd_rs == FWD_EX_OLD_ALU && ex_old.is_load)))
            else $error("rs takes a load address from execute without a stall.");
    end

endmodule

`default_nettype wire

// ==== source/register_file.sv ====
`default_nettype none

module register_file import bypass_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  reg_addr_t         raddr_0,
    input  reg_addr_t         raddr_1,
    input  reg_addr_t         raddr_2,
    input  reg_addr_t         raddr_3,
    output logic [data_w-1:0] rdata_0,
    output logic [data_w-1:0] rdata_1,
    output logic [data_w-1:0] rdata_2,
    output logic [data_w-1:0] rdata_3,
    input  logic              we_0,
    input  reg_addr_t         waddr_0,
    input  logic [data_w-1:0] wdata_0,
    input  logic              we_1,
    input  reg_addr_t         waddr_1,
    input  logic [data_w-1:0] wdata_1
);

    logic [data_w-1:0] regs [32];

    // slot 1 is checked first so that it wins the bypass as it wins the write.
    function automatic logic [data_w-1:0] read_port(input reg_addr_t addr);
        logic [data_w-1:0] val;
        if (addr == '0) begin
            val = '0;
        end else if (we_1 && waddr_1 == addr) begin
            val = wdata_1;
        end else if (we_0 && waddr_0 == addr) begin
            val = wdata_0;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_comb begin
        rdata_0 = read_port(raddr_0);
        rdata_1 = read_port(raddr_1);
        rdata_2 = read_port(raddr_2);
        rdata_3 = read_port(raddr_3);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (we_0 && waddr_0 != '0) begin
                regs[waddr_0] <= wdata_0;
            end
            if (we_1 && waddr_1 != '0) begin
                regs[waddr_1] <= wdata_1; // the later assignment lets slot 1 win.
            end
        end
    end

    a_reg_zero_kept: assert property (@(posedge clk) disable iff (!rst_n) regs[0] == '0)
        else $error("register 0 was written.");

endmodule

`default_nettype wire

// ==== source/exec_lane.sv ====
`default_nettype none

module exec_lane import bypass_pkg::*; #(
    parameter  int mem_depth = 64,
    localparam int addr_w    = $clog2(mem_depth)
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  logic              id_valid,
    input  instr_t            id_instr,
    input  logic [data_w-1:0] opa,
    input  logic [data_w-1:0] opb,
    lane_result_if.producer   ex_res,
    lane_result_if.producer   mem_res,
    output logic [addr_w-1:0] mem_addr,
    input  logic [data_w-1:0] mem_rdata,
    output logic              wb_valid,
    output reg_addr_t         wb_dst,
    output logic [data_w-1:0] wb_data
);

    logic              ex_valid;
    op_t               ex_op;
    reg_addr_t         ex_dst;
    imm_t              ex_imm;
    logic [data_w-1:0] ex_opa;
    logic [data_w-1:0] ex_opb;
    logic [data_w-1:0] alu_out;

    logic              mem_valid;
    reg_addr_t         mem_dst;
    logic              mem_is_load;
    logic [data_w-1:0] mem_alu;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid  <= 1'b0;
            mem_valid <= 1'b0;
            wb_valid  <= 1'b0;
        end else begin
            ex_valid  <= id_valid & ~flush; // a flush leaves a bubble in execute.
            mem_valid <= ex_valid;
            wb_valid  <= mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_op   <= id_instr.op;
        ex_dst  <= (id_instr.op == OP_NOP) ? reg_addr_t'(0) : id_instr.dst;
        ex_imm  <= id_instr.imm;
        ex_opa  <= opa;
        ex_opb  <= opb;
        mem_dst     <= ex_dst;
        mem_is_load <= (ex_op == OP_LOAD);
        mem_alu     <= alu_out;
        wb_dst  <= mem_dst;
        wb_data <= mem_is_load ? mem_rdata : mem_alu;
    end

    always_comb begin
        unique case (ex_op)
            OP_ADD:  alu_out = ex_opa + ex_opb;
            OP_SUB:  alu_out = ex_opa - ex_opb;
            OP_AND:  alu_out = ex_opa & ex_opb;
            OP_OR:   alu_out = ex_opa | ex_opb;
            OP_LOAD: alu_out = ex_opa + data_w'(ex_imm); // the offset is zero-extended.
            default: alu_out = '0;
        endcase
    end

    assign ex_res.valid     = ex_valid;
    assign ex_res.w_ena     = ex_valid & (ex_dst != '0);
    assign ex_res.dst       = ex_dst;
    assign ex_res.is_load   = (ex_op == OP_LOAD);
    assign ex_res.alu_res   = alu_out;
    assign ex_res.load_data = '0;

    assign mem_addr = mem_alu[addr_w-1:0];

    assign mem_res.valid     = mem_valid;
    assign mem_res.w_ena     = mem_valid & (mem_dst != '0);
    assign mem_res.dst       = mem_dst;
    assign mem_res.is_load   = mem_is_load;
    assign mem_res.alu_res   = mem_alu;
    assign mem_res.load_data = mem_rdata;

    a_load_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_valid && mem_is_load) |-> (mem_alu < mem_depth))
        else $error("load address %0h is outside the data memory.", mem_alu);

endmodule

`default_nettype wire

// ==== source/data_memory.sv ====
`default_nettype none

module data_memory import bypass_pkg::*; #(
    parameter  int mem_depth = 64,
    localparam int addr_w    = $clog2(mem_depth)
) (
    input  logic              clk,
    input  logic [addr_w-1:0] raddr_0,
    input  logic [addr_w-1:0] raddr_1,
    output logic [data_w-1:0] rdata_0,
    output logic [data_w-1:0] rdata_1,
    input  logic              we,
    input  logic [addr_w-1:0] waddr,
    input  logic [data_w-1:0] wdata
);

    logic [data_w-1:0] mem [mem_depth];

    // one read port per lane, so loads in both slots complete together.
    assign rdata_0 = mem[raddr_0];
    assign rdata_1 = mem[raddr_1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

endmodule

`default_nettype wire

// ==== source/bypass_core.sv ====
`default_nettype none

module bypass_core import bypass_pkg::*; #(
    parameter  int mem_depth = 64,
    localparam int addr_w    = $clog2(mem_depth)
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              issue_valid,
    output logic              issue_ready,
    input  op_t               slot0_op,
    input  reg_addr_t         slot0_rs,
    input  reg_addr_t         slot0_rt,
    input  reg_addr_t         slot0_dst,
    input  imm_t              slot0_imm,
    input  op_t               slot1_op,
    input  reg_addr_t         slot1_rs,
    input  reg_addr_t         slot1_rt,
    input  reg_addr_t         slot1_dst,
    input  imm_t              slot1_imm,
    input  logic              mem_we,
    input  logic [addr_w-1:0] mem_waddr,
    input  logic [data_w-1:0] mem_wdata,
    output logic              retire_valid_0,
    output reg_addr_t         retire_dst_0,
    output logic [data_w-1:0] retire_data_0,
    output logic              retire_valid_1,
    output reg_addr_t         retire_dst_1,
    output logic [data_w-1:0] retire_data_1
);

    logic              id_valid;
    instr_t            id_instr_0;
    instr_t            id_instr_1;
    logic              stall;
    logic              stall_req_0;
    logic              stall_req_1;
    fwd_sel_t          fwd_rs_0;
    fwd_sel_t          fwd_rt_0;
    fwd_sel_t          fwd_rs_1;
    fwd_sel_t          fwd_rt_1;
    logic [data_w-1:0] rf_rs_0;
    logic [data_w-1:0] rf_rt_0;
    logic [data_w-1:0] rf_rs_1;
    logic [data_w-1:0] rf_rt_1;
    logic [data_w-1:0] opa_0;
    logic [data_w-1:0] opb_0;
    logic [data_w-1:0] opa_1;
    logic [data_w-1:0] opb_1;
    logic [addr_w-1:0] mem_addr_0;
    logic [addr_w-1:0] mem_addr_1;
    logic [data_w-1:0] mem_rdata_0;
    logic [data_w-1:0] mem_rdata_1;

    lane_result_if ex_res_0 ();
    lane_result_if ex_res_1 ();
    lane_result_if mem_res_0 ();
    lane_result_if mem_res_1 ();

    function automatic logic [data_w-1:0] pick_operand(
        input fwd_sel_t          sel,
        input logic [data_w-1:0] rf_val,
        input logic [data_w-1:0] ex_old_alu,
        input logic [data_w-1:0] ex_young_alu,
        input logic [data_w-1:0] mem_old_alu,
        input logic [data_w-1:0] mem_old_load,
        input logic [data_w-1:0] mem_young_alu,
        input logic [data_w-1:0] mem_young_load
    );
        logic [data_w-1:0] val;
        case (sel)
            FWD_EX_YOUNG_ALU:   val = ex_young_alu;
            FWD_EX_OLD_ALU:     val = ex_old_alu;
            FWD_MEM_YOUNG_ALU:  val = mem_young_alu;
            FWD_MEM_YOUNG_LOAD: val = mem_young_load;
            FWD_MEM_OLD_ALU:    val = mem_old_alu;
            FWD_MEM_OLD_LOAD:   val = mem_old_load;
            default:            val = rf_val;
        endcase
        return val;
    endfunction

    assign stall       = stall_req_0 | stall_req_1;
    assign issue_ready = ~stall;

    // an empty decode holds zero fields, so it can never match or stall.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid   <= 1'b0;
            id_instr_0 <= '0;
            id_instr_1 <= '0;
        end else if (issue_valid && issue_ready) begin
            id_valid   <= 1'b1;
            id_instr_0 <= '{op: slot0_op, rs: slot0_rs, rt: slot0_rt, dst: slot0_dst,
                            imm: slot0_imm};
            id_instr_1 <= '{op: slot1_op, rs: slot1_rs, rt: slot1_rt, dst: slot1_dst,
                            imm: slot1_imm};
        end else if (!stall) begin
            id_valid   <= 1'b0;
            id_instr_0 <= '0;
            id_instr_1 <= '0;
        end
    end

    assign opa_0 = pick_operand(fwd_rs_0, rf_rs_0, ex_res_0.alu_res, ex_res_1.alu_res,
                                mem_res_0.alu_res, mem_res_0.load_data,
                                mem_res_1.alu_res, mem_res_1.load_data);
    assign opb_0 = pick_operand(fwd_rt_0, rf_rt_0, ex_res_0.alu_res, ex_res_1.alu_res,
                                mem_res_0.alu_res, mem_res_0.load_data,
                                mem_res_1.alu_res, mem_res_1.load_data);
    assign opa_1 = pick_operand(fwd_rs_1, rf_rs_1, ex_res_0.alu_res, ex_res_1.alu_res,
                                mem_res_0.alu_res, mem_res_0.load_data,
                                mem_res_1.alu_res, mem_res_1.load_data);
    assign opb_1 = pick_operand(fwd_rt_1, rf_rt_1, ex_res_0.alu_res, ex_res_1.alu_res,
                                mem_res_0.alu_res, mem_res_0.load_data,
                                mem_res_1.alu_res, mem_res_1.load_data);

    operand_forward u_fwd_0 (
        .id_rs(id_instr_0.rs), .id_rt(id_instr_0.rt),
        .ex_old(ex_res_0), .ex_young(ex_res_1), .mem_old(mem_res_0), .mem_young(mem_res_1),
        .fwd_rs(fwd_rs_0), .fwd_rt(fwd_rt_0), .stall_req(stall_req_0)
    );

    operand_forward u_fwd_1 (
        .id_rs(id_instr_1.rs), .id_rt(id_instr_1.rt),
        .ex_old(ex_res_0), .ex_young(ex_res_1), .mem_old(mem_res_0), .mem_young(mem_res_1),
        .fwd_rs(fwd_rs_1), .fwd_rt(fwd_rt_1), .stall_req(stall_req_1)
    );

    // retiring results are written at the end of their retire cycle.
    register_file u_regs (
        .clk(clk), .rst_n(rst_n),
        .raddr_0(id_instr_0.rs), .raddr_1(id_instr_0.rt),
        .raddr_2(id_instr_1.rs), .raddr_3(id_instr_1.rt),
        .rdata_0(rf_rs_0), .rdata_1(rf_rt_0), .rdata_2(rf_rs_1), .rdata_3(rf_rt_1),
        .we_0(retire_valid_0), .waddr_0(retire_dst_0), .wdata_0(retire_data_0),
        .we_1(retire_valid_1), .waddr_1(retire_dst_1), .wdata_1(retire_data_1)
    );

    exec_lane #(.mem_depth(mem_depth)) u_lane_0 (
        .clk(clk), .rst_n(rst_n), .flush(stall), .id_valid(id_valid), .id_instr(id_instr_0),
        .opa(opa_0), .opb(opb_0), .ex_res(ex_res_0), .mem_res(mem_res_0),
        .mem_addr(mem_addr_0), .mem_rdata(mem_rdata_0),
        .wb_valid(retire_valid_0), .wb_dst(retire_dst_0), .wb_data(retire_data_0)
    );

    exec_lane #(.mem_depth(mem_depth)) u_lane_1 (
        .clk(clk), .rst_n(rst_n), .flush(stall), .id_valid(id_valid), .id_instr(id_instr_1),
        .opa(opa_1), .opb(opb_1), .ex_res(ex_res_1), .mem_res(mem_res_1),
        .mem_addr(mem_addr_1), .mem_rdata(mem_rdata_1),
        .wb_valid(retire_valid_1), .wb_dst(retire_dst_1), .wb_data(retire_data_1)
    );

    data_memory #(.mem_depth(mem_depth)) u_dmem (
        .clk(clk),
        .raddr_0(mem_addr_0), .raddr_1(mem_addr_1),
        .rdata_0(mem_rdata_0), .rdata_1(mem_rdata_1),
        .we(mem_we), .waddr(mem_waddr), .wdata(mem_wdata)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_bypass_core.sv ====
`default_nettype none

module tb_bypass_core import bypass_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int bundle_count = 64; // directed bundles plus the random stream.

    logic              clk;
    logic              rst_n;
    logic              issue_valid;
    logic              issue_ready;
    instr_t            slot0;
    instr_t            slot1;
    logic              mem_we;
    logic [5:0]        mem_waddr;
    logic [data_w-1:0] mem_wdata;
    logic              retire_valid_0;
    reg_addr_t         retire_dst_0;
    logic [data_w-1:0] retire_data_0;
    logic              retire_valid_1;
    reg_addr_t         retire_dst_1;
    logic [data_w-1:0] retire_data_1;

    logic [data_w-1:0] model_regs [32];
    logic [data_w-1:0] mem_img [64];
    logic [36:0]       exp_q [$];       // {dst, data} in retire order.
    int                seed = 98925;
    int                stall_cycles;

    bypass_core #(.mem_depth(64)) UUT (
        .clk(clk), .rst_n(rst_n), .issue_valid(issue_valid), .issue_ready(issue_ready),
        .slot0_op(slot0.op), .slot0_rs(slot0.rs), .slot0_rt(slot0.rt),
        .slot0_dst(slot0.dst), .slot0_imm(slot0.imm),
        .slot1_op(slot1.op), .slot1_rs(slot1.rs), .slot1_rt(slot1.rt),
        .slot1_dst(slot1.dst), .slot1_imm(slot1.imm),
        .mem_we(mem_we), .mem_waddr(mem_waddr), .mem_wdata(mem_wdata),
        .retire_valid_0(retire_valid_0), .retire_dst_0(retire_dst_0),
        .retire_data_0(retire_data_0), .retire_valid_1(retire_valid_1),
        .retire_dst_1(retire_dst_1), .retire_data_1(retire_data_1)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [data_w-1:0] got,
                               input logic [data_w-1:0] expected);
        if (got !== expected) begin
            stop_on_error($sformatf("ERR %s: got 0x%h, expected 0x%h", name, got, expected));
        end
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic instr_t make_instr(input op_t op, input int rs, input int rt,
                                          input int dst, input int imm);
        instr_t ins;
        ins.op  = op;
        ins.rs  = reg_addr_t'(rs);
        ins.rt  = reg_addr_t'(rt);
        ins.dst = reg_addr_t'(dst);
        ins.imm = imm_t'(imm);
        return ins;
    endfunction

    function automatic instr_t random_instr();
        op_t op;
        int  rs;
        int  rt;
        op = op_t'(3'(rand_below(6)));
        rs = rand_below(32);
        rt = rand_below(32);
        if (op == OP_LOAD) begin
            rs = 0; // keeps the load address equal to imm.
            rt = 0;
        end
        return make_instr(op, rs, rt, rand_below(32), rand_below(64));
    endfunction

    // the model runs each slot in program order, so no bypass path enters the prediction.
    task automatic predict_retire(input instr_t ins);
        logic [data_w-1:0] a;
        logic [data_w-1:0] b;
        logic [data_w-1:0] res;
        reg_addr_t         dst;
        a   = model_regs[ins.rs];
        b   = model_regs[ins.rt];
        dst = (ins.op == OP_NOP) ? reg_addr_t'(0) : ins.dst;
        case (ins.op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_LOAD: res = mem_img[6'(a + data_w'(ins.imm))];
            default: res = '0;
        endcase
        if (dst != '0) begin
            model_regs[dst] = res;
        end
        exp_q.push_back({dst, res});
    endtask

    task automatic send(input instr_t s0, input instr_t s1);
        issue_valid <= 1'b1;
        slot0       <= s0;
        slot1       <= s1;
        @(negedge clk);
        while (!issue_ready) begin
            stall_cycles++;
            @(negedge clk);
        end
        @(posedge clk); // the bundle is taken at this edge.
        predict_retire(s0);
        predict_retire(s1);
    endtask

    task automatic go_idle(input int cycles);
        issue_valid <= 1'b0;
        slot0       <= '0;
        slot1       <= '0;
        repeat (cycles) @(posedge clk);
    endtask

    task automatic compare_retire(input int slot, input reg_addr_t dst,
                                  input logic [data_w-1:0] data);
        logic [36:0] expected;
        if (exp_q.size() == 0) begin
            stop_on_error($sformatf("slot %0d retired with no instruction outstanding", slot));
        end else begin
            expected = exp_q.pop_front();
            check_value($sformatf("retire_dst_%0d", slot), data_w'(dst),
                        data_w'(expected[36:32]));
            check_value($sformatf("retire_data_%0d", slot), data, expected[31:0]);
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && retire_valid_0) begin
            compare_retire(0, retire_dst_0, retire_data_0);
        end
        if (rst_n && retire_valid_1) begin
            compare_retire(1, retire_dst_1, retire_data_1);
        end
    end

    initial begin
        repeat (20 * bundle_count + 200) @(posedge clk);
        stop_on_error("timeout: the tests did not finish in the allowed number of cycles");
    end

    task automatic wait_for_retire();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > 20) begin
                stop_on_error("an expected retirement never arrived");
            end
        end
    endtask

    task automatic preload_memory();
        for (int a = 0; a < 64; a++) begin
            mem_img[a] = $random(seed);
            mem_we    <= 1'b1;
            mem_waddr <= 6'(a);
            mem_wdata <= mem_img[a];
            @(posedge clk);
        end
        mem_we <= 1'b0;
    endtask

    task automatic load_registers();
        for (int i = 0; i < 8; i++) begin
            send(make_instr(OP_LOAD, 0, 0, 2 * i + 1, 3 * i),
                 make_instr(OP_LOAD, 0, 0, 2 * i + 2, 3 * i + 1));
        end
        go_idle(6);
    endtask

    task automatic chain_alu_results();
        send(make_instr(OP_ADD, 1, 2, 10, 0), make_instr(OP_SUB, 3, 4, 11, 0));
        send(make_instr(OP_OR, 10, 11, 12, 0), make_instr(OP_AND, 11, 10, 13, 0));
        send(make_instr(OP_ADD, 10, 11, 14, 0), make_instr(OP_SUB, 11, 10, 15, 0));
        send(make_instr(OP_SUB, 13, 12, 16, 0), make_instr(OP_OR, 14, 15, 17, 0));
        go_idle(6);
    endtask

    task automatic prefer_young_slot();
        send(make_instr(OP_ADD, 1, 2, 20, 0), make_instr(OP_SUB, 3, 4, 20, 0));
        send(make_instr(OP_ADD, 20, 0, 21, 0), make_instr(OP_OR, 5, 20, 22, 0));
        go_idle(6);
    endtask

    task automatic stall_on_load_use();
        instr_t nop;
        nop = make_instr(OP_NOP, 0, 0, 0, 0);
        stall_cycles = 0;
        send(make_instr(OP_LOAD, 0, 0, 24, 5), nop);
        send(make_instr(OP_ADD, 24, 1, 25, 0), make_instr(OP_OR, 2, 24, 26, 0));
        send(nop, nop);
        if (stall_cycles == 0) begin
            stop_on_error("issue_ready stayed high across a load-use hazard");
        end
        stall_cycles = 0;
        send(nop, make_instr(OP_LOAD, 0, 0, 27, 9));
        send(make_instr(OP_ADD, 1, 2, 28, 0), nop);
        send(make_instr(OP_ADD, 27, 3, 29, 0), make_instr(OP_SUB, 28, 27, 30, 0));
        send(nop, nop);
        if (stall_cycles != 0) begin
            stop_on_error("a load two bundles ahead stalled the issue port");
        end
        go_idle(6);
    endtask

    task automatic write_zero_and_same_dst();
        send(make_instr(OP_ADD, 1, 2, 0, 0), make_instr(OP_OR, 3, 4, 0, 0));
        send(make_instr(OP_ADD, 0, 5, 23, 0), make_instr(OP_OR, 0, 6, 18, 0));
        go_idle(6);
        send(make_instr(OP_OR, 20, 0, 19, 0), make_instr(OP_ADD, 0, 0, 31, 0));
        go_idle(6);
    endtask

    task automatic run_random_stream();
        instr_t s0;
        instr_t s1;
        for (int i = 0; i < 40; i++) begin
            s0 = random_instr();
            s1 = random_instr();
            s1.rs = (s1.rs == s0.dst) ? reg_addr_t'(0) : s1.rs; // no reads of slot 0's result.
            s1.rt = (s1.rt == s0.dst) ? reg_addr_t'(0) : s1.rt;
            send(s0, s1);
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        issue_valid  = 1'b0;
        slot0        = '0;
        slot1        = '0;
        mem_we       = 1'b0;
        mem_waddr    = '0;
        mem_wdata    = '0;
        stall_cycles = 0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("issue_ready", data_w'(issue_ready), 1);
        @(posedge clk);
        preload_memory();
        load_registers();
        chain_alu_results();
        prefer_young_slot();
        stall_on_load_use();
        write_zero_and_same_dst();
        run_random_stream();
        go_idle(1);
        wait_for_retire();
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
source/bypass_pkg.sv
source/lane_result_if.sv
source/operand_forward.sv
source/register_file.sv
source/exec_lane.sv
source/data_memory.sv
source/bypass_core.sv
testbench/tb_bypass_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_bypass_core
FILELIST  := sources.f
FLAGS     := --timing --assert --timescale 1ns/1ps
OBJ_DIR   := obj_dir
PASS      := All tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; echo "$$out" | grep -qF "$(PASS)"

clean:
	rm -rf $(OBJ_DIR)
